// ==== hdl/scc_pkg.sv ====
`default_nettype none

package scc_pkg;

    // CPU address window of the sound chips, limit is exclusive
    localparam logic [15:0] SCC_BASE  = 16'h9800;    // First address of the window
    localparam logic [15:0] SCC_LIMIT = 16'hA000;    // First address past the window

    localparam int NUM_CHIPS = 2;                    // Sound chips behind the decoder
    localparam int NUM_CH    = 5;                    // Channels per chip
    localparam int CE_DIV    = 4;                    // clock_bus cycles per sound enable

    // Register map on the low 8 address bits
    localparam logic [7:0] REG_WAVE_END = 8'h80;     // Waveform RAM below this offset
    localparam logic [7:0] REG_FREQ     = 8'h80;     // 12-bit periods, low byte first
    localparam logic [7:0] REG_VOL      = 8'h8A;     // 4-bit volumes, one byte each
    localparam logic [7:0] REG_MASK     = 8'h8F;     // Channel enable mask

    typedef enum logic [1:0] {
        DEV_NONE,                                    // No device targeted
        DEV_SCC,                                     // Wavetable sound chip
        DEV_PSG                                      // Other sound device, never hit here
    } device_t;

    typedef struct packed {
        device_t typ;                                // Device kind of this bus cycle
        logic    num;                                // Device number within its kind
    } dev_sel_t;

    typedef struct packed {
        logic    valid;                              // One-cycle command strobe
        device_t typ;                                // Device kind to configure
        logic    num;                                // Device number to configure
        logic    en;                                 // New enable state
    } dev_cfg_t;

    typedef struct packed {
        logic        cyc;                            // Bus cycle in progress
        logic        stb;                            // Strobe, valid transfer
        logic        we;                             // Write when high
        logic [15:0] adr;                            // CPU address
        logic [7:0]  dat;                            // Write data
    } wb_req_t;

    typedef struct packed {
        logic       ack;                             // One-cycle acknowledge
        logic       hit;                             // Cycle reached an enabled chip
        logic [7:0] dat;                             // Read data, FF on a miss
    } wb_rsp_t;

    typedef struct packed {
        logic       wr;                              // Single-cycle write strobe
        logic       rd;                              // Single-cycle read strobe
        logic [7:0] adr;                             // Offset inside the window
        logic [7:0] dat;                             // Write data
    } chip_req_t;

endpackage

`default_nettype wire

// ==== hdl/scc_wave.sv ====
`timescale 1ns/1ps
`default_nettype none

module scc_wave (
    input  logic                 clock_bus,          // System clock
    input  logic                 reset,              // Synchronous reset, active high
    input  logic                 clkena,             // Sound clock enable
    input  scc_pkg::chip_req_t   req,                // Access strobe from the decoder
    output logic [7:0]           dat,                // Registered read data
    output logic signed [14:0]   wave                // Registered channel mix
);

    // Kind of register an access offset lands on
    typedef enum logic [1:0] {
        ACC_WAVE,                                    // Waveform RAM, 8'h00 to 8'h7F
        ACC_FREQ,                                    // Period bytes
        ACC_VOL,                                     // Volume bytes
        ACC_MASK                                     // Channel enable mask
    } acc_t;

    logic [7:0]         ram [128];                   // Four 32-byte tables
    logic [11:0]        period [scc_pkg::NUM_CH];    // Reload value per channel
    logic [3:0]         vol [scc_pkg::NUM_CH];       // Volume per channel
    logic [scc_pkg::NUM_CH-1:0] mask;                // Channel enable mask

    logic [11:0]        count [scc_pkg::NUM_CH];     // Down-counters in enables
    logic [4:0]         phase [scc_pkg::NUM_CH];     // Waveform index per channel

    logic [7:0]         reg_off;                     // Offset with the 8'h90+ mirror folded
    acc_t               acc;                         // Decoded access kind
    logic [3:0]         freq_idx;                    // Byte index inside the period block
    logic [2:0]         freq_ch;                     // Channel of a period byte
    logic [2:0]         vol_ch;                      // Channel of a volume byte

    logic signed [7:0]  sample [scc_pkg::NUM_CH];    // Current table byte per channel
    logic signed [12:0] prod [scc_pkg::NUM_CH];      // Byte times volume
    logic signed [14:0] mix_sum;                     // Sum over enabled channels

    // Offsets above 8'h8F repeat the 16-byte control block
    assign reg_off  = {4'h8, req.adr[3:0]};
    assign freq_idx = 4'(reg_off - scc_pkg::REG_FREQ);
    assign freq_ch  = freq_idx[3:1];                 // Two bytes per channel
    assign vol_ch   = 3'(reg_off - scc_pkg::REG_VOL);

    always_comb begin
        if (req.adr < scc_pkg::REG_WAVE_END) begin
            acc = ACC_WAVE;
        end else if (reg_off < scc_pkg::REG_VOL) begin
            acc = ACC_FREQ;
        end else if (reg_off < scc_pkg::REG_MASK) begin
            acc = ACC_VOL;
        end else begin
            acc = ACC_MASK;
        end
    end

    // Waveform RAM, cleared so that playback starts silent
    always_ff @(posedge clock_bus) begin
        if (reset) begin
            for (int i = 0; i < 128; i++) begin
                ram[i] <= '0;
            end
        end else if (req.wr && acc == ACC_WAVE) begin
            ram[req.adr[6:0]] <= req.dat;            // Channel 3 table also feeds channel 4
        end
    end

    // Period, volume and mask registers
    always_ff @(posedge clock_bus) begin
        if (reset) begin
            for (int ch = 0; ch < scc_pkg::NUM_CH; ch++) begin
                period[ch] <= '0;
                vol[ch]    <= '0;
            end
            mask <= '0;
        end else if (req.wr) begin
            case (acc)
                ACC_FREQ: begin
                    if (freq_idx[0]) begin
                        period[freq_ch][11:8] <= req.dat[3:0];  // High nibble
                    end else begin
                        period[freq_ch][7:0] <= req.dat;        // Low byte
                    end
                end
                ACC_VOL:  vol[vol_ch] <= req.dat[3:0];
                ACC_MASK: mask <= req.dat[scc_pkg::NUM_CH-1:0];
                default:  ;                          // RAM handled above
            endcase
        end
    end

    // Read data is captured on the strobe and held for the acknowledge cycle
    always_ff @(posedge clock_bus) begin
        if (req.rd) begin
            dat <= (acc == ACC_WAVE) ? ram[req.adr[6:0]] : 8'hFF;
        end
    end

    // Phase counters, index steps once every period+1 enables
    always_ff @(posedge clock_bus) begin
        if (reset) begin
            for (int ch = 0; ch < scc_pkg::NUM_CH; ch++) begin
                count[ch] <= '0;
                phase[ch] <= '0;
            end
        end else if (clkena) begin
            for (int ch = 0; ch < scc_pkg::NUM_CH; ch++) begin
                if (count[ch] == '0) begin
                    count[ch] <= period[ch];         // Reload on terminal count
                    phase[ch] <= phase[ch] + 5'd1;   // Wraps at 32
                end else begin
                    count[ch] <= count[ch] - 12'd1;
                end
            end
        end
    end

    // Table lookup and volume scaling
    always_comb begin
        for (int ch = 0; ch < scc_pkg::NUM_CH; ch++) begin
            logic [1:0] tab;                         // Table used by this channel
            tab = (ch == scc_pkg::NUM_CH - 1) ? 2'd3 : 2'(ch);
            sample[ch] = $signed(ram[{tab, phase[ch]}]);
            prod[ch]   = sample[ch] * $signed({1'b0, vol[ch]});
        end
    end

    always_comb begin
        mix_sum = '0;
        for (int ch = 0; ch < scc_pkg::NUM_CH; ch++) begin
            if (mask[ch]) begin
                mix_sum = mix_sum + prod[ch];        // Peak 5 x 128 x 15 fits in 15 bits
            end
        end
    end

    always_ff @(posedge clock_bus) begin
        if (reset) begin
            wave <= '0;
        end else if (clkena) begin
            wave <= mix_sum;                         // Sampled at the sound rate
        end
    end

endmodule

`default_nettype wire

// ==== hdl/scc_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module scc_bus_decode (
    input  logic                 clock_bus,                       // System clock
    input  logic                 reset,                           // Synchronous reset
    input  scc_pkg::wb_req_t     wb_req,                          // Wishbone request
    input  scc_pkg::dev_sel_t    dev_sel,                         // Target device of the cycle
    input  scc_pkg::dev_cfg_t    dev_cfg,                         // Enable command
    input  logic [7:0]           chip_dat [scc_pkg::NUM_CHIPS],   // Registered chip read data
    output scc_pkg::wb_rsp_t     wb_rsp,                          // Wishbone response
    output scc_pkg::chip_req_t   chip_req [scc_pkg::NUM_CHIPS]    // Per-chip access strobes
);

    logic [scc_pkg::NUM_CHIPS-1:0] chip_en;          // Per-chip enable state
    logic in_window;                                 // Address inside 9800-9FFF
    logic cs;                                        // Cycle targets an enabled chip
    logic start;                                     // First sampled cycle of a strobe
    logic ack_q;                                     // Registered acknowledge
    logic hit_q;                                     // Registered hit flag
    logic served;                                    // Strobe already answered
    logic num_q;                                     // Chip whose data goes on the bus

    // Enable registers, a command acts on cycles starting after its edge
    always_ff @(posedge clock_bus) begin
        if (reset) begin
            chip_en <= '0;                           // Both chips start disabled
        end else if (dev_cfg.valid && dev_cfg.typ == scc_pkg::DEV_SCC) begin
            chip_en[dev_cfg.num] <= dev_cfg.en;
        end
    end

    assign in_window = (wb_req.adr >= scc_pkg::SCC_BASE) &&
                       (wb_req.adr <  scc_pkg::SCC_LIMIT);

    assign cs = (dev_sel.typ == scc_pkg::DEV_SCC) && in_window && chip_en[dev_sel.num];

    // No new transfer while ack is out or the same strobe is still held
    assign start = wb_req.cyc && wb_req.stb && !ack_q && !served;

    always_ff @(posedge clock_bus) begin
        if (reset) begin
            ack_q  <= 1'b0;
            hit_q  <= 1'b0;
            served <= 1'b0;
        end else begin
            ack_q  <= start;                         // Every strobe gets one ack
            hit_q  <= start && cs;
            served <= wb_req.cyc && wb_req.stb && (served || ack_q);  // Clears when stb drops
        end
    end

    always_ff @(posedge clock_bus) begin
        if (start) begin
            num_q <= dev_sel.num;                    // Held for the read mux
        end
    end

    // One strobe for the addressed chip, in the cycle ack is registered
    always_comb begin
        for (int i = 0; i < scc_pkg::NUM_CHIPS; i++) begin
            logic sel;                               // This chip is the target
            sel = start && cs && (dev_sel.num == 1'(i));
            chip_req[i].wr  = sel && wb_req.we;
            chip_req[i].rd  = sel && !wb_req.we;
            chip_req[i].adr = wb_req.adr[7:0];
            chip_req[i].dat = wb_req.dat;
        end
    end

    // Misses and idle cycles float high on the data bus
    assign wb_rsp.ack = ack_q;
    assign wb_rsp.hit = hit_q;
    assign wb_rsp.dat = hit_q ? chip_dat[num_q] : 8'hFF;

endmodule

`default_nettype wire

// ==== hdl/scc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module scc_top (
    input  logic                 clock_bus,          // System clock
    input  logic                 reset,              // Synchronous reset, active high
    input  scc_pkg::wb_req_t     wb_req,             // CPU bus request
    input  scc_pkg::dev_sel_t    dev_sel,            // Target of the current cycle
    input  scc_pkg::dev_cfg_t    dev_cfg,            // Device enable command
    input  logic [1:0]           mix_enable,         // Chips that reach the output
    output scc_pkg::wb_rsp_t     wb_rsp,             // CPU bus response
    output logic signed [15:0]   sound               // Mixed sound output
);

    typedef logic [$clog2(scc_pkg::CE_DIV)-1:0] ce_cnt_t;

    ce_cnt_t                 ce_cnt;                                  // Prescaler state
    logic                    clkena;                                  // Sound clock enable
    logic [7:0]              chip_dat  [scc_pkg::NUM_CHIPS];          // Chip read data
    scc_pkg::chip_req_t      chip_req  [scc_pkg::NUM_CHIPS];          // Chip access strobes
    logic signed [14:0]      chip_wave [scc_pkg::NUM_CHIPS];          // Chip sound levels

    // Sound clock enable, one pulse every CE_DIV cycles
    always_ff @(posedge clock_bus) begin
        if (reset) begin
            ce_cnt <= '0;
        end else if (ce_cnt == ce_cnt_t'(scc_pkg::CE_DIV - 1)) begin
            ce_cnt <= '0;
        end else begin
            ce_cnt <= ce_cnt + ce_cnt_t'(1);
        end
    end

    assign clkena = (ce_cnt == ce_cnt_t'(scc_pkg::CE_DIV - 1));

    scc_bus_decode u_decode (
        .clock_bus (clock_bus),
        .reset     (reset),
        .wb_req    (wb_req),
        .dev_sel   (dev_sel),
        .dev_cfg   (dev_cfg),
        .chip_dat  (chip_dat),
        .wb_rsp    (wb_rsp),
        .chip_req  (chip_req)
    );

    for (genvar i = 0; i < scc_pkg::NUM_CHIPS; i++) begin : g_chip
        scc_wave u_wave (
            .clock_bus (clock_bus),
            .reset     (reset),
            .clkena    (clkena),
            .req       (chip_req[i]),
            .dat       (chip_dat[i]),
            .wave      (chip_wave[i])
        );
    end

    // Sign-extend each chip level and add the ones let through
    always_comb begin
        sound = '0;
        for (int i = 0; i < scc_pkg::NUM_CHIPS; i++) begin
            if (mix_enable[i]) begin
                sound = sound + $signed({chip_wave[i][14], chip_wave[i]});
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/scc_tb_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module scc_tb_sva (
    input logic              clock_bus,              // System clock
    input logic              reset,                  // Synchronous reset
    input scc_pkg::wb_req_t  wb_req,                 // Request at the top-level port
    input scc_pkg::wb_rsp_t  wb_rsp                  // Response at the top-level port
);

    int unsigned fail_count = 0;                     // Failed properties, read by the testbench

    // ack answers a strobe sampled one edge earlier
    ack_after_stb: assert property (
        @(posedge clock_bus) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
    ) else begin
        fail_count++;
        $error("ack raised without cyc and stb in the previous cycle");
    end

    // Single-cycle acknowledge even with stb still held
    ack_one_cycle: assert property (
        @(posedge clock_bus) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else begin
        fail_count++;
        $error("ack held high for two cycles");
    end

    ack_with_hit: assert property (
        @(posedge clock_bus) disable iff (reset)
        wb_rsp.hit |-> wb_rsp.ack
    ) else begin
        fail_count++;
        $error("hit raised outside an acknowledge");
    end

    // A miss floats the data bus high
    miss_reads_ff: assert property (
        @(posedge clock_bus) disable iff (reset)
        (wb_rsp.ack && !wb_rsp.hit) |-> (wb_rsp.dat == 8'hFF)
    ) else begin
        fail_count++;
        $error("acknowledge without hit carries data other than FF");
    end

endmodule

`default_nettype wire

// ==== testbench/scc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scc_tb;

    localparam int ACK_TIMEOUT   = 16;               // Cycles allowed for one acknowledge
    localparam int SOUND_TIMEOUT = 1200;             // Cycles allowed for a sound level

    logic                clock_bus;
    logic                reset;
    scc_pkg::wb_req_t    wb_req;
    scc_pkg::dev_sel_t   dev_sel;
    scc_pkg::dev_cfg_t   dev_cfg;
    logic [1:0]          mix_enable;
    scc_pkg::wb_rsp_t    wb_rsp;
    logic signed [15:0]  sound;

    integer              seed;                       // $random state
    logic [7:0]          model [128];                // Expected chip 0 waveform RAM
    logic [7:0]          rd_dat;
    logic                rd_hit;
    logic [7:0]          old_val;                    // Byte that misses must not change
    logic [7:0]          c0, c1, a, b;               // Waveform constants
    logic [19:0]         vol0, vol1;                 // Five packed 4-bit volumes
    logic [4:0]          m0, m1;                     // Channel masks

    scc_top DUT (
        .clock_bus  (clock_bus),
        .reset      (reset),
        .wb_req     (wb_req),
        .dev_sel    (dev_sel),
        .dev_cfg    (dev_cfg),
        .mix_enable (mix_enable),
        .wb_rsp     (wb_rsp),
        .sound      (sound)
    );

    bind scc_top scc_tb_sva u_sva (
        .clock_bus (clock_bus),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    initial begin
        clock_bus = 1'b0;
        forever #10 clock_bus = ~clock_bus;          // 20 ns period
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Bus protocol properties of the bound checker
    always @(negedge clock_bus) begin
        if (DUT.u_sva.fail_count != 0) begin
            fail_now("A bus protocol assertion failed");
        end
    end

    function automatic scc_pkg::dev_sel_t target_scc(input logic num);
        return '{typ: scc_pkg::DEV_SCC, num: num};
    endfunction

    // Sum over audible channels of the flat byte c times each volume
    function automatic int chip_level(input logic [7:0] c, input logic [19:0] vols,
                                      input logic [4:0] m);
        int sum;
        sum = 0;
        for (int i = 0; i < scc_pkg::NUM_CH; i++) begin
            if (m[i]) begin
                sum += int'($signed(c)) * int'(vols[4*i +: 4]);
            end
        end
        return sum;
    endfunction

    // One classic cycle with the request held until ack and stb dropped the edge after
    task automatic wb_transfer(input logic we, input scc_pkg::dev_sel_t sel,
                               input logic [15:0] adr, input logic [7:0] wdat,
                               output logic [7:0] dat, output logic hit);
        int waited;
        waited = 0;
        @(posedge clock_bus);
        wb_req  <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        dev_sel <= sel;
        do begin
            @(negedge clock_bus);                    // Outputs settled mid-cycle
            waited++;
            if (waited > ACK_TIMEOUT) begin
                fail_now("Timeout while waiting for the bus acknowledge");
            end
        end while (!wb_rsp.ack);
        dat = wb_rsp.dat;
        hit = wb_rsp.hit;
        @(posedge clock_bus);
        wb_req <= '0;
    endtask

    task automatic wb_write(input scc_pkg::dev_sel_t sel, input logic [15:0] adr,
                            input logic [7:0] wdat, output logic hit);
        logic [7:0] unused_dat;
        wb_transfer(1'b1, sel, adr, wdat, unused_dat, hit);
    endtask

    task automatic wb_read(input scc_pkg::dev_sel_t sel, input logic [15:0] adr,
                           output logic [7:0] dat, output logic hit);
        wb_transfer(1'b0, sel, adr, 8'h00, dat, hit);
    endtask

    task automatic chip_write(input logic num, input logic [7:0] off, input logic [7:0] wdat);
        logic hit;
        wb_write(target_scc(num), {scc_pkg::SCC_BASE[15:8], off}, wdat, hit);
        check_value("wb_rsp.hit", 32'(hit), 32'd1);
    endtask

    task automatic chip_read_check(input logic num, input logic [7:0] off,
                                   input logic [7:0] exp);
        logic [7:0] dat;
        logic       hit;
        wb_read(target_scc(num), {scc_pkg::SCC_BASE[15:8], off}, dat, hit);
        check_value("wb_rsp.hit", 32'(hit), 32'd1);
        check_value("wb_rsp.dat", 32'(dat), 32'(exp));
    endtask

    task automatic set_enable(input logic num, input logic en);
        @(posedge clock_bus);
        dev_cfg <= '{valid: 1'b1, typ: scc_pkg::DEV_SCC, num: num, en: en};
        @(posedge clock_bus);
        dev_cfg <= '0;                               // One-cycle command
    endtask

    // Flat table, volumes and mask for one chip
    task automatic program_level(input logic num, input logic [7:0] c,
                                 input logic [19:0] vols, input logic [4:0] m);
        for (int i = 0; i < 128; i++) begin
            chip_write(num, 8'(i), c);
        end
        for (int i = 0; i < scc_pkg::NUM_CH; i++) begin
            chip_write(num, scc_pkg::REG_VOL + 8'(i), {4'h0, vols[4*i +: 4]});
        end
        chip_write(num, scc_pkg::REG_MASK, {3'b000, m});
    endtask

    task automatic set_mix(input logic [1:0] en);
        @(posedge clock_bus);
        mix_enable <= en;
    endtask

    // Waits for a level and then checks that it holds for hold cycles
    task automatic wait_sound(input int exp, input int hold);
        int waited;
        waited = 0;
        do begin
            @(negedge clock_bus);
            waited++;
        end while (sound !== 16'(exp) && waited < SOUND_TIMEOUT);
        check_value("sound", 32'(sound), 32'(exp));
        for (int i = 0; i < hold; i++) begin
            @(negedge clock_bus);
            check_value("sound", 32'(sound), 32'(exp));
        end
    endtask

    initial begin
        seed       = 32'h737afcc2;
        reset      = 1'b1;
        wb_req     = '0;
        dev_sel    = '0;
        dev_cfg    = '0;
        mix_enable = 2'b11;                          // Both chip outputs reach sound
        repeat (3) @(posedge clock_bus);
        reset <= 1'b0;

        // Quiet bus and silent output out of reset with both chips disabled
        @(negedge clock_bus);
        check_value("wb_rsp.ack", 32'(wb_rsp.ack), 32'd0);
        check_value("wb_rsp.hit", 32'(wb_rsp.hit), 32'd0);
        check_value("sound", 32'(sound), 32'd0);
        wb_read(target_scc(1'b0), 16'h9800, rd_dat, rd_hit);
        check_value("wb_rsp.hit", 32'(rd_hit), 32'd0);
        check_value("wb_rsp.dat", 32'(rd_dat), 32'hFF);

        // Waveform RAM of chip 0 reads back including the channel 3 area
        set_enable(1'b0, 1'b1);
        for (int i = 0; i < 128; i++) begin
            model[i] = 8'($random(seed));
            chip_write(1'b0, 8'(i), model[i]);
        end
        for (int i = 0; i < 128; i++) begin
            chip_read_check(1'b0, 8'(i), model[i]);
        end
        chip_read_check(1'b0, 8'h8F, 8'hFF);
        chip_read_check(1'b0, 8'h90, 8'hFF);
        chip_read_check(1'b0, 8'hFF, 8'hFF);

        // Misses by device kind, window and disabled chip leave RAM alone
        old_val = model[5];
        wb_write('{typ: scc_pkg::DEV_PSG, num: 1'b0}, 16'h9805, ~old_val, rd_hit);
        check_value("wb_rsp.hit", 32'(rd_hit), 32'd0);
        wb_write(target_scc(1'b0), 16'hA005, ~old_val, rd_hit);
        check_value("wb_rsp.hit", 32'(rd_hit), 32'd0);
        wb_write(target_scc(1'b0), 16'h9705, ~old_val, rd_hit);
        check_value("wb_rsp.hit", 32'(rd_hit), 32'd0);
        wb_write(target_scc(1'b1), 16'h9805, ~old_val, rd_hit);
        check_value("wb_rsp.hit", 32'(rd_hit), 32'd0);
        wb_read('{typ: scc_pkg::DEV_NONE, num: 1'b0}, 16'h9805, rd_dat, rd_hit);
        check_value("wb_rsp.hit", 32'(rd_hit), 32'd0);
        check_value("wb_rsp.dat", 32'(rd_dat), 32'hFF);
        chip_read_check(1'b0, 8'h05, old_val);
        set_enable(1'b1, 1'b1);
        chip_read_check(1'b1, 8'h05, 8'h00);         // Chip 1 still cleared
        chip_write(1'b1, 8'h05, ~old_val);
        chip_read_check(1'b0, 8'h05, old_val);
        chip_read_check(1'b1, 8'h05, ~old_val);

        // Flat waveform on chip 0 held over a full table sweep
        c0   = 8'($random(seed)) | 8'h10;
        vol0 = 20'($random(seed)) | 20'h00001;      // Channel 0 never muted
        m0   = 5'($random(seed)) | 5'b00001;
        program_level(1'b0, c0, vol0, m0);
        set_mix(2'b01);
        wait_sound(chip_level(c0, vol0, m0), 140);

        // Mixing of two chip levels
        c1   = c0 ^ 8'h4A;                           // Keeps bit 4, so never zero
        vol1 = 20'($random(seed)) | 20'h00010;      // Channel 1 never muted
        m1   = 5'($random(seed)) | 5'b00010;
        program_level(1'b1, c1, vol1, m1);
        set_mix(2'b11);
        wait_sound(chip_level(c0, vol0, m0) + chip_level(c1, vol1, m1), 20);
        set_mix(2'b10);
        wait_sound(chip_level(c1, vol1, m1), 20);
        set_mix(2'b00);
        wait_sound(0, 20);

        // Channel 0 steps between two half-table values
        a = 8'($random(seed)) | 8'h02;
        b = a ^ 8'h81;
        for (int i = 0; i < 32; i++) begin
            chip_write(1'b0, 8'(i), (i < 16) ? a : b);
        end
        chip_write(1'b0, scc_pkg::REG_FREQ, 8'd3);
        chip_write(1'b0, scc_pkg::REG_FREQ + 8'd1, 8'd0);
        chip_write(1'b0, scc_pkg::REG_VOL, 8'd15);
        chip_write(1'b0, scc_pkg::REG_MASK, 8'h01);
        set_mix(2'b01);
        wait_sound(15 * int'($signed(a)), 0);
        wait_sound(15 * int'($signed(b)), 240);     // Half table is 16 x 4 enables x 4 cycles

        if (DUT.u_sva.fail_count != 0) begin
            fail_now("A bus protocol assertion failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/scc_pkg.sv
hdl/scc_wave.sv
hdl/scc_bus_decode.sv
hdl/scc_top.sv
testbench/scc_tb_sva.sv
testbench/scc_tb.sv

// ==== Makefile ====
# Verilator build and run for the SCC sound subsystem testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = scc_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = === FAIL ===

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A stopped simulation or the fail message in the log marks the run as failed
run: $(BIN)
	@status=0; $(BIN) > $(LOG) 2>&1 || status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -- "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation finished cleanly"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
